// File: rtl/lumi_pkg.sv
// shared types and register map of the link control block
// every register access is one 32-bit word, no byte sizes or bursts
// group/offset address only, the offset is decoded on word boundaries
package lumi_pkg;

   // ##############################
   // register port
   // ##############################

   // request from the register master
   typedef struct packed {
      logic        write;   // 1 = write, 0 = read
      logic [7:0]  grp;     // group id, must match GRPID
      logic [7:0]  offset;  // register byte offset
      logic [31:0] data;    // write data
   } reg_req_t;

   // response, one per request
   typedef struct packed {
      logic        write;   // echo of the request type
      logic        err;     // foreign group or read miss
      logic [31:0] data;    // read data, zero on writes
   } reg_resp_t;

   // ##############################
   // link state
   // ##############################
   typedef enum logic [1:0] {
      LINK_IDLE   = 2'd0,
      LINK_WAIT   = 2'd1,
      LINK_ACTIVE = 2'd2
   } link_state_e;

   // register outputs used by the rest of the link
   typedef struct packed {
      logic [1:0]  arbmode;          // crossbar arbitration mode
      logic        txen;             // gated by linkactive
      logic        txcrdt_en;        // send credit updates
      logic [7:0]  txiowidth;        // tx pad bus width in bytes
      logic        rxen;             // gated by linkactive
      logic [7:0]  rxiowidth;        // rx pad bus width in bytes
      logic [15:0] txcrdt_intrvl;    // cycles between credit updates, minus one
      logic [15:0] rxcrdt_req_init;  // initial request credits
      logic [15:0] rxcrdt_resp_init; // initial response credits
   } csr_t;

   // ##############################
   // register offsets
   // ##############################
   localparam logic [7:0] LUMI_CTRL       = 8'h00;
   localparam logic [7:0] LUMI_STATUS     = 8'h04;
   localparam logic [7:0] LUMI_TXMODE     = 8'h08;
   localparam logic [7:0] LUMI_RXMODE     = 8'h0C;
   localparam logic [7:0] LUMI_CRDTINIT   = 8'h10;
   localparam logic [7:0] LUMI_CRDTINTRVL = 8'h14;
   localparam logic [7:0] LUMI_CRDTSTAT   = 8'h18;

   // field positions, tx and rx mode share a layout
   localparam int MODE_EN_BIT      = 0;
   localparam int MODE_CRDT_EN_BIT = 4;
   localparam int MODE_IOW_LSB     = 16;
   localparam int MODE_IOW_MSB     = 23;

   localparam int CTRL_ARB_LSB = 4;
   localparam int CTRL_ARB_MSB = 5;

   // status layout, link-lost is clear on write 1
   localparam int STAT_LOST_BIT   = 0;
   localparam int STAT_STATE_LSB  = 1;
   localparam int STAT_STATE_MSB  = 2;
   localparam int STAT_ACTIVE_BIT = 3;

endpackage

// File: rtl/lumi_regif.sv
// register request/response port, one transaction in flight at a time
// response comes two cycles after the request is accepted
// a request to another group gets an error and no register access
module lumi_regif
   import lumi_pkg::*;
   #(parameter logic [7:0] GRPID = 8'h00)
   (input  logic        clk,
    input  logic        nreset,
    // request side
    input  logic        req_valid,
    input  reg_req_t    req,
    output logic        req_ready,
    // response side
    output logic        resp_valid,
    output reg_resp_t   resp,
    input  logic        resp_ready,
    // register file access
    output logic        reg_write,
    output logic        reg_read,
    output logic [7:0]  reg_offset,
    output logic [31:0] reg_wrdata,
    input  logic [31:0] rd_data,
    input  logic        rd_miss);

   // sequencer phases
   localparam logic [1:0] S_IDLE   = 2'd0;
   localparam logic [1:0] S_ACCESS = 2'd1;
   localparam logic [1:0] S_BUILD  = 2'd2;
   localparam logic [1:0] S_RESP   = 2'd3;

   logic [1:0] state;
   logic       accept;
   logic       grp_hit;
   reg_req_t   req_q;
   reg_resp_t  resp_next;
   reg_resp_t  resp_q;

   // ##############################
   // request capture
   // ##############################

   // ready only when idle, so a held response blocks new requests
   assign req_ready = (state == S_IDLE);
   assign accept    = req_valid & req_ready;

   always_ff @(posedge clk) begin
      if (accept) begin
         req_q <= req;
      end
   end

   assign grp_hit = (req_q.grp == GRPID);

   // ##############################
   // sequencer
   // ##############################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         state <= S_IDLE;
      end else begin
         case (state)
            S_IDLE: begin
               if (accept) begin
                  state <= S_ACCESS;
               end
            end
            // strobe cycle
            S_ACCESS: state <= S_BUILD;
            // read data is registered now
            S_BUILD:  state <= S_RESP;
            S_RESP: begin
               if (resp_ready) begin
                  state <= S_IDLE;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   // single cycle strobes, only for our group
   assign reg_write  = (state == S_ACCESS) & grp_hit & req_q.write;
   assign reg_read   = (state == S_ACCESS) & grp_hit & ~req_q.write;
   assign reg_offset = req_q.offset;
   assign reg_wrdata = req_q.data;

   // ##############################
   // response build and hold
   // ##############################
   always_comb begin
      resp_next.write = req_q.write;
      // miss only counts on reads, a write to a hole is dropped quietly
      resp_next.err   = ~grp_hit | (~req_q.write & rd_miss);
      resp_next.data  = (grp_hit & ~req_q.write) ? rd_data : 32'h0;
   end

   // stays put while resp_ready is low
   always_ff @(posedge clk) begin
      if (state == S_BUILD) begin
         resp_q <= resp_next;
      end
   end

   assign resp_valid = (state == S_RESP);
   assign resp       = resp_q;

endmodule

// File: rtl/lumi_regs.sv
// control, mode and credit registers of the link
// offsets decoded on word boundaries, bits 1:0 of the offset are ignored
// unknown offsets read zero with a miss, writes to them are dropped
module lumi_regs
   import lumi_pkg::*;
   #(parameter logic [31:0] CRDT_INIT_RST = {16'd42, 16'd42})
   (input  logic        clk,
    input  logic        nreset,
    // access from the register port
    input  logic        reg_write,
    input  logic        reg_read,
    input  logic [7:0]  reg_offset,
    input  logic [31:0] reg_wrdata,
    output logic [31:0] rd_data,
    output logic        rd_miss,
    // link state
    input  logic        linkactive,
    input  link_state_e link_state,
    input  logic        link_lost,
    output logic        clear_lost,
    // credit status from the tx side
    input  logic [31:0] txcrdt_status,
    // timer restart
    output logic        intrvl_wr,
    output csr_t        csr);

   logic [31:0] ctrl_reg;
   logic [31:0] txmode_reg;
   logic [31:0] rxmode_reg;
   logic [31:0] crdt_init_reg;
   logic [15:0] intrvl_reg;

   logic        write_ctrl;
   logic        write_status;
   logic        write_txmode;
   logic        write_rxmode;
   logic        write_crdt_init;
   logic        write_crdt_intrvl;

   logic [31:0] status_word;
   logic [31:0] rd_mux;
   logic        miss_mux;

   // ##############################
   // write decode
   // ##############################
   assign write_ctrl        = reg_write & (reg_offset[7:2] == LUMI_CTRL[7:2]);
   assign write_status      = reg_write & (reg_offset[7:2] == LUMI_STATUS[7:2]);
   assign write_txmode      = reg_write & (reg_offset[7:2] == LUMI_TXMODE[7:2]);
   assign write_rxmode      = reg_write & (reg_offset[7:2] == LUMI_RXMODE[7:2]);
   assign write_crdt_init   = reg_write & (reg_offset[7:2] == LUMI_CRDTINIT[7:2]);
   assign write_crdt_intrvl = reg_write & (reg_offset[7:2] == LUMI_CRDTINTRVL[7:2]);

   // w1c on the lost flag, the rest of status is read only
   assign clear_lost = write_status & reg_wrdata[STAT_LOST_BIT];

   // ##############################
   // registers
   // ##############################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         ctrl_reg      <= 32'h0;
         // tx/rx stay off until the host has set up the link
         txmode_reg    <= 32'h0;
         rxmode_reg    <= 32'h0;
         crdt_init_reg <= CRDT_INIT_RST;
         intrvl_reg    <= 16'h00FF;
      end else begin
         if (write_ctrl) begin
            ctrl_reg <= reg_wrdata;
         end
         if (write_txmode) begin
            txmode_reg <= reg_wrdata;
         end
         if (write_rxmode) begin
            rxmode_reg <= reg_wrdata;
         end
         if (write_crdt_init) begin
            crdt_init_reg <= reg_wrdata;
         end
         if (write_crdt_intrvl) begin
            intrvl_reg <= reg_wrdata[15:0];
         end
      end
   end

   // delayed one cycle so the timer reloads the new interval
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         intrvl_wr <= 1'b0;
      end else begin
         intrvl_wr <= write_crdt_intrvl;
      end
   end

   // ##############################
   // status and read mux
   // ##############################
   always_comb begin
      status_word                                = 32'h0;
      status_word[STAT_LOST_BIT]                 = link_lost;
      status_word[STAT_STATE_MSB:STAT_STATE_LSB] = link_state;
      status_word[STAT_ACTIVE_BIT]               = linkactive;
   end

   always_comb begin
      miss_mux = 1'b0;
      case (reg_offset[7:2])
         LUMI_CTRL[7:2]:       rd_mux = ctrl_reg;
         LUMI_STATUS[7:2]:     rd_mux = status_word;
         LUMI_TXMODE[7:2]:     rd_mux = txmode_reg;
         LUMI_RXMODE[7:2]:     rd_mux = rxmode_reg;
         LUMI_CRDTINIT[7:2]:   rd_mux = crdt_init_reg;
         LUMI_CRDTINTRVL[7:2]: rd_mux = {16'h0, intrvl_reg};
         LUMI_CRDTSTAT[7:2]:   rd_mux = txcrdt_status;
         default: begin
            rd_mux   = 32'h0;
            miss_mux = 1'b1;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (reg_read) begin
         rd_data <= rd_mux;
      end
   end

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         rd_miss <= 1'b0;
      end else if (reg_read) begin
         rd_miss <= miss_mux;
      end
   end

   // ##############################
   // register outputs
   // ##############################
   always_comb begin
      csr.arbmode          = ctrl_reg[CTRL_ARB_MSB:CTRL_ARB_LSB];
      // enables only count while the link is up
      csr.txen             = linkactive & txmode_reg[MODE_EN_BIT];
      csr.txcrdt_en        = txmode_reg[MODE_CRDT_EN_BIT];
      csr.txiowidth        = txmode_reg[MODE_IOW_MSB:MODE_IOW_LSB];
      csr.rxen             = linkactive & rxmode_reg[MODE_EN_BIT];
      csr.rxiowidth        = rxmode_reg[MODE_IOW_MSB:MODE_IOW_LSB];
      csr.txcrdt_intrvl    = intrvl_reg;
      csr.rxcrdt_req_init  = crdt_init_reg[15:0];
      csr.rxcrdt_resp_init = crdt_init_reg[31:16];
   end

endmodule

// File: rtl/lumi_link_fsm.sv
// link bring-up state machine, one transition per clock
// devicemode 1 is host, a device also waits for device_ready
module lumi_link_fsm
   import lumi_pkg::*;
   (input  logic        clk,
    input  logic        nreset,
    input  logic        devicemode,
    input  logic        device_ready,
    input  logic        phy_linkactive,
    // w1c from the status register
    input  logic        clear_lost,
    output link_state_e link_state,
    output logic        linkactive,
    output logic        link_lost);

   link_state_e state;
   link_state_e state_next;
   logic        drop;

   // ##############################
   // next state
   // ##############################
   always_comb begin
      state_next = state;
      case (state)
         LINK_IDLE: begin
            if (phy_linkactive) begin
               state_next = LINK_WAIT;
            end
         end
         LINK_WAIT: begin
            if (!phy_linkactive) begin
               state_next = LINK_IDLE;
            end else if (devicemode | device_ready) begin
               // host goes straight through
               state_next = LINK_ACTIVE;
            end
         end
         LINK_ACTIVE: begin
            if (!phy_linkactive) begin
               state_next = LINK_IDLE;
            end
         end
         default: state_next = LINK_IDLE;
      endcase
   end

   // leaving active, whatever the reason
   assign drop = (state == LINK_ACTIVE) & (state_next != LINK_ACTIVE);

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         state      <= LINK_IDLE;
         linkactive <= 1'b0;
      end else begin
         state      <= state_next;
         // same edge as the state, so it tracks LINK_ACTIVE exactly
         linkactive <= (state_next == LINK_ACTIVE);
      end
   end

   // sticky lost flag, a new drop wins over a clear
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         link_lost <= 1'b0;
      end else if (drop) begin
         link_lost <= 1'b1;
      end else if (clear_lost) begin
         link_lost <= 1'b0;
      end
   end

   assign link_state = state;

endmodule

// File: rtl/lumi_crdt_timer.sv
// credit update pacing, one pulse every intrvl+1 cycles while running
// held at intrvl when stopped or restarted
module lumi_crdt_timer
   (input  logic        clk,
    input  logic        nreset,
    // credit enable and tx enable
    input  logic        run,
    input  logic [15:0] intrvl,
    // interval register was written
    input  logic        restart,
    output logic        crdt_update);

   logic [15:0] cnt;
   logic        expire;

   // ##############################
   // interval counter
   // ##############################
   assign expire = (cnt == 16'h0);

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         cnt <= 16'h0;
      end else if (!run || restart) begin
         cnt <= intrvl;
      end else if (expire) begin
         // reload for the next period
         cnt <= intrvl;
      end else begin
         cnt <= cnt - 16'd1;
      end
   end

   // pulse on the reload edge
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         crdt_update <= 1'b0;
      end else begin
         crdt_update <= run & ~restart & expire;
      end
   end

endmodule

// File: rtl/lumi_ctrl.sv
// top of the link control block, wiring only
// the credit status word comes straight from the tx credit logic
module lumi_ctrl
   import lumi_pkg::*;
   #(parameter logic [7:0]  GRPID         = 8'h00,
     parameter logic [31:0] CRDT_INIT_RST = {16'd42, 16'd42})
   (input  logic        clk,
    input  logic        nreset,
    input  logic        devicemode,
    input  logic        device_ready,
    input  logic        phy_linkactive,
    // register port
    input  logic        req_valid,
    input  reg_req_t    req,
    output logic        req_ready,
    output logic        resp_valid,
    output reg_resp_t   resp,
    input  logic        resp_ready,
    input  logic [31:0] txcrdt_status,
    output logic        host_linkactive,
    output csr_t        csr,
    output logic        crdt_update);

   logic        reg_write;
   logic        reg_read;
   logic [7:0]  reg_offset;
   logic [31:0] reg_wrdata;
   logic [31:0] rd_data;
   logic        rd_miss;
   logic        clear_lost;
   logic        intrvl_wr;
   link_state_e link_state;
   logic        link_lost;

   lumi_regif #(.GRPID(GRPID)) i_lumi_regif (
      .clk, .nreset,
      .req_valid, .req, .req_ready,
      .resp_valid, .resp, .resp_ready,
      .reg_write, .reg_read, .reg_offset, .reg_wrdata,
      .rd_data, .rd_miss);

   lumi_regs #(.CRDT_INIT_RST(CRDT_INIT_RST)) i_lumi_regs (
      .clk, .nreset,
      .reg_write, .reg_read, .reg_offset, .reg_wrdata,
      .rd_data, .rd_miss,
      .linkactive(host_linkactive),
      .link_state, .link_lost, .clear_lost,
      .txcrdt_status, .intrvl_wr, .csr);

   lumi_link_fsm i_lumi_link_fsm (
      .clk, .nreset,
      .devicemode, .device_ready, .phy_linkactive,
      .clear_lost, .link_state,
      .linkactive(host_linkactive),
      .link_lost);

   // runs only with credits on and tx enabled on a live link
   lumi_crdt_timer i_lumi_crdt_timer (
      .clk, .nreset,
      .run(csr.txcrdt_en & csr.txen),
      .intrvl(csr.txcrdt_intrvl),
      .restart(intrvl_wr),
      .crdt_update);

endmodule

// File: dv/lumi_ctrl_tb.sv
// testbench for lumi_ctrl, driven by dv/lumi_ctrl_tests.txt
// run from the project root, all test file fields are hex
// GRPID is left at 0, only group 0 reaches the register file
module lumi_ctrl_tb
   import lumi_pkg::*;
   ();
   timeunit 1ns;
   timeprecision 100ps;

   localparam logic [7:0] GRPID        = 8'h00;
   localparam int         RESET_CYCLES = 5;
   // worst case per line, the credit checks are the longest
   localparam int         TEST_BOUND   = 100;

   logic        clk;
   logic        nreset;
   logic        devicemode;
   logic        device_ready;
   logic        phy_linkactive;
   logic        req_valid;
   reg_req_t    req;
   logic        req_ready;
   logic        resp_valid;
   reg_resp_t   resp;
   logic        resp_ready;
   logic [31:0] txcrdt_status;
   logic        host_linkactive;
   csr_t        csr;
   logic        crdt_update;

   integer      seed = 32'hc540;
   int          cycles = 0;
   int          cycle_limit = 0;

   // expected register contents, follow the writes in the test file
   logic [31:0] exp_ctrl;
   logic [31:0] exp_txmode;
   logic [31:0] exp_rxmode;
   logic [31:0] exp_crdt_init;
   logic [15:0] exp_intrvl;

   lumi_ctrl #(.GRPID(GRPID)) i_lumi_ctrl (
      .clk, .nreset,
      .devicemode, .device_ready, .phy_linkactive,
      .req_valid, .req, .req_ready,
      .resp_valid, .resp, .resp_ready,
      .txcrdt_status, .host_linkactive, .csr, .crdt_update);

   // ##############################
   // clock and timeout
   // ##############################
   always #50 clk = ~clk;

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycle_limit != 0 && cycles > cycle_limit) begin
         stop_run($sformatf("timeout, no progress after %0d cycles", cycles));
      end
   end

   // ##############################
   // helpers
   // ##############################
   task automatic stop_run(input string why);
      $display("%s", why);
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         stop_run($sformatf("MISMATCH at %0d ns: %s expected %h actual %h",
                            $time, name, expected, actual));
      end
   endtask

   // inputs change 5 ns after the edge, outputs are settled there too
   task automatic next_cycle();
      @(posedge clk);
      #5;
   endtask

   task automatic skip_line(input int fd);
      int ch;
      ch = $fgetc(fd);
      while (ch != -1 && ch != 10) begin
         ch = $fgetc(fd);
      end
   endtask

   // next command letter, comment lines skipped
   task automatic next_command(input int fd, output logic [7:0] cmd, output bit found);
      int code;
      code = $fscanf(fd, " %c", cmd);
      while (code == 1 && cmd == "#") begin
         skip_line(fd);
         code = $fscanf(fd, " %c", cmd);
      end
      found = (code == 1);
   endtask

   task automatic update_expected(input logic [7:0] offset, input logic [31:0] data);
      case (offset)
         8'h00: exp_ctrl = data;
         8'h08: exp_txmode = data;
         8'h0C: exp_rxmode = data;
         8'h10: exp_crdt_init = data;
         8'h14: exp_intrvl = data[15:0];
         default: ;
      endcase
   endtask

   // fields of csr that do not depend on the link
   task automatic check_csr_fields();
      check_value("csr.arbmode", 32'(csr.arbmode), 32'(exp_ctrl[5:4]));
      check_value("csr.txcrdt_en", 32'(csr.txcrdt_en), 32'(exp_txmode[4]));
      check_value("csr.txiowidth", 32'(csr.txiowidth), 32'(exp_txmode[23:16]));
      check_value("csr.rxiowidth", 32'(csr.rxiowidth), 32'(exp_rxmode[23:16]));
      check_value("csr.txcrdt_intrvl", 32'(csr.txcrdt_intrvl), 32'(exp_intrvl));
      check_value("csr.rxcrdt_req_init", 32'(csr.rxcrdt_req_init),
                  32'(exp_crdt_init[15:0]));
      check_value("csr.rxcrdt_resp_init", 32'(csr.rxcrdt_resp_init),
                  32'(exp_crdt_init[31:16]));
   endtask

   // one request and its response, with random resp_ready stalls
   task automatic reg_access(input logic wr, input logic [15:0] addr,
                             input logic [31:0] data, output reg_resp_t rsp);
      reg_resp_t held;
      int        lat;
      bit        done;
      req.write  = wr;
      req.grp    = addr[15:8];
      req.offset = addr[7:0];
      req.data   = data;
      req_valid  = 1'b1;
      while (!req_ready) begin
         next_cycle();
      end
      // accepted on this edge
      next_cycle();
      req_valid = 1'b0;
      lat = 0;
      while (!resp_valid) begin
         check_value("req_ready", 32'(req_ready), 32'd0);
         next_cycle();
         lat++;
      end
      check_value("response latency", 32'(lat), 32'd2);
      done = 1'b0;
      while (!done) begin
         check_value("req_ready", 32'(req_ready), 32'd0);
         resp_ready = ($random(seed) % 3) != 0;
         held = resp;
         if (resp_ready) begin
            rsp  = resp;
            done = 1'b1;
         end
         next_cycle();
         if (!done) begin
            // stalled, response must not move
            check_value("resp_valid", 32'(resp_valid), 32'd1);
            check_value("resp.write", 32'(resp.write), 32'(held.write));
            check_value("resp.err", 32'(resp.err), 32'(held.err));
            check_value("resp.data", resp.data, held.data);
         end
      end
      resp_ready = 1'b0;
      check_value("resp_valid", 32'(resp_valid), 32'd0);
      check_value("req_ready", 32'(req_ready), 32'd1);
   endtask

   // k+1 cycles between consecutive pulses
   task automatic check_pulses(input logic [31:0] k, input logic [31:0] n);
      int gap;
      int i;
      while (!crdt_update) begin
         next_cycle();
      end
      for (i = 0; i < n; i++) begin
         gap = 0;
         do begin
            next_cycle();
            gap++;
         end while (!crdt_update);
         check_value("crdt_update period", 32'(gap), k + 32'd1);
      end
   endtask

   // ##############################
   // main sequence
   // ##############################
   initial begin
      int          fd;
      int          n_tests;
      int          nf;
      int          need;
      bit          found;
      logic [7:0]  cmd;
      logic [31:0] f1;
      logic [31:0] f2;
      logic [31:0] f3;
      reg_resp_t   rsp;

      clk            = 1'b0;
      nreset         = 1'b0;
      devicemode     = 1'b0;
      device_ready   = 1'b0;
      phy_linkactive = 1'b0;
      req_valid      = 1'b0;
      req            = '0;
      resp_ready     = 1'b0;
      txcrdt_status  = 32'h005500AA;
      exp_ctrl       = 32'h0;
      exp_txmode     = 32'h0;
      exp_rxmode     = 32'h0;
      exp_crdt_init  = {16'd42, 16'd42};
      exp_intrvl     = 16'h00FF;

      // first pass counts the commands for the timeout
      fd = $fopen("dv/lumi_ctrl_tests.txt", "r");
      if (fd == 0) begin
         stop_run("cannot open test file dv/lumi_ctrl_tests.txt");
      end
      n_tests = 0;
      next_command(fd, cmd, found);
      while (found) begin
         n_tests++;
         skip_line(fd);
         next_command(fd, cmd, found);
      end
      $fclose(fd);
      cycle_limit = RESET_CYCLES + 2 + n_tests * TEST_BOUND;

      repeat (RESET_CYCLES) begin
         next_cycle();
      end
      nreset = 1'b1;
      check_value("req_ready", 32'(req_ready), 32'd1);
      check_value("resp_valid", 32'(resp_valid), 32'd0);
      check_value("crdt_update", 32'(crdt_update), 32'd0);
      check_value("host_linkactive", 32'(host_linkactive), 32'd0);
      check_value("csr.txen", 32'(csr.txen), 32'd0);
      check_value("csr.rxen", 32'(csr.rxen), 32'd0);
      check_csr_fields();
      next_cycle();

      fd = $fopen("dv/lumi_ctrl_tests.txt", "r");
      next_command(fd, cmd, found);
      while (found) begin
         f1 = '0;
         f2 = '0;
         f3 = '0;
         case (cmd)
            "S": begin
               need = 1;
               nf   = $fscanf(fd, "%h", f1);
            end
            "T": begin
               need = 2;
               nf   = $fscanf(fd, "%h %h", f1, f2);
            end
            default: begin
               need = 3;
               nf   = $fscanf(fd, "%h %h %h", f1, f2, f3);
            end
         endcase
         if (nf != need) begin
            stop_run($sformatf("malformed test line for command %c", cmd));
         end
         case (cmd)
            "P": begin
               devicemode     = f1[0];
               device_ready   = f2[0];
               phy_linkactive = f3[0];
            end
            "W": begin
               reg_access(1'b1, f1[15:0], f2, rsp);
               check_value("resp.write", 32'(rsp.write), 32'd1);
               check_value("resp.err", 32'(rsp.err), f3);
               check_value("resp.data", rsp.data, 32'd0);
               if (f1[15:8] == GRPID) begin
                  update_expected(f1[7:0], f2);
               end
               check_csr_fields();
            end
            "R": begin
               reg_access(1'b0, f1[15:0], 32'h0, rsp);
               check_value("resp.write", 32'(rsp.write), 32'd0);
               check_value("resp.err", 32'(rsp.err), f3);
               check_value("resp.data", rsp.data, f2);
            end
            "C": begin
               check_value("host_linkactive", 32'(host_linkactive), f1);
               check_value("csr.txen", 32'(csr.txen), f2);
               check_value("csr.rxen", 32'(csr.rxen), f3);
            end
            "T": check_pulses(f1, f2);
            "S": begin
               repeat (f1) begin
                  next_cycle();
               end
            end
            default: stop_run($sformatf("unknown command %c in test file", cmd));
         endcase
         next_command(fd, cmd, found);
      end
      $fclose(fd);
      $display("Simulation passed");
      $finish;
   end

endmodule

// File: dv/lumi_ctrl_tests.txt
# P devmode devrdy phyup | W addr data err | R addr data err | C linkactive txen rxen
# T interval gaps | S cycles | addr is group and offset, all fields hex
R 0000 00000000 0
R 0004 00000000 0
R 0008 00000000 0
R 000C 00000000 0
R 0010 002A002A 0
R 0014 000000FF 0
R 0018 005500AA 0
W 0000 00000030 0
R 0000 00000030 0
W 0008 00A50011 0
R 0008 00A50011 0
W 000C 005A0001 0
R 000C 005A0001 0
W 0010 00200010 0
R 0010 00200010 0
W 0014 00000007 0
R 0014 00000007 0
R 001C 00000000 1
R 0040 00000000 1
W 0020 12345678 0
R 0020 00000000 1
R 0100 00000000 1
W 0300 00000001 1
C 0 0 0
# host mode, phy up
P 1 0 1
S 3
C 1 1 1
R 0004 0000000C 0
T 7 3
W 0014 00000003 0
T 3 4
# phy drop sets link-lost
P 1 0 0
S 2
C 0 0 0
R 0004 00000001 0
W 0004 00000001 0
R 0004 00000000 0
# device mode waits for device_ready
P 0 0 1
S 3
R 0004 00000002 0
C 0 0 0
P 0 1 1
S 2
C 1 1 1
R 0004 0000000C 0
W 0008 00A50010 0
C 1 0 1

// File: lumi_ctrl.f
rtl/lumi_pkg.sv
rtl/lumi_regif.sv
rtl/lumi_regs.sv
rtl/lumi_link_fsm.sv
rtl/lumi_crdt_timer.sv
rtl/lumi_ctrl.sv
dv/lumi_ctrl_tb.sv

// File: Makefile
TOOL   = verilator
FLAGS  = --binary --timing
TOP    = lumi_ctrl_tb
FLIST  = lumi_ctrl.f
OBJDIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf $(OBJDIR)
